/* source/board_pkg.sv */
// shared board-control types and constants, imported by every block of the glue logic
`default_nettype none

package board_pkg;

    // game buttons, active high when pressed
    typedef struct packed {
        logic start;
        logic sel;
        logic b;
        logic a;
        logic up;
        logic right;
        logic left;
        logic down;
    } game_buttons_t;

    // buttons forwarded by the microcontroller
    typedef struct packed {
        logic          menu;
        game_buttons_t game;
    } mcu_buttons_t;

    // single-cycle enables from the timebase
    typedef struct packed {
        logic second;
        logic half_second;
        logic percent;
    } tick_t;

    // led requests, highest priority first
    typedef struct packed {
        logic white;
        logic green;
        logic yellow;
        logic red;
    } led_req_t;

    // rgb pin levels, active low
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    typedef logic [31:0] game_hash_t;

    localparam int unsigned CART_HIST_LEN = 18;
    localparam int unsigned SYNC_STAGES   = 2;

endpackage

`default_nettype wire

/* source/board_timebase.sv */
// second, half-second and percent enable generator plus led blink state, runs on gClk
`timescale 1ns/1ps
`default_nettype none

module board_timebase #(
    parameter int unsigned TICKS_PER_SECOND  = 8388608,
    parameter int unsigned TICKS_PER_PERCENT = 83887
) (
    input  logic             gClk,
    input  logic             lock_o,
    output board_pkg::tick_t ticks_o,
    output logic             blink_o
);

    localparam int unsigned SEC_W = $clog2(TICKS_PER_SECOND);
    localparam int unsigned PCT_W = $clog2(TICKS_PER_PERCENT);

    localparam logic [SEC_W-1:0] SEC_LAST  = SEC_W'(TICKS_PER_SECOND - 1);
    localparam logic [SEC_W-1:0] HALF_LAST = SEC_W'(TICKS_PER_SECOND / 2 - 1);
    localparam logic [PCT_W-1:0] PCT_LAST  = PCT_W'(TICKS_PER_PERCENT - 1);

    logic [SEC_W-1:0] sec_cnt;
    logic [PCT_W-1:0] pct_cnt;
    logic             sec_wrap;
    logic             half_hit;
    logic             pct_wrap;

    assign sec_wrap = (sec_cnt == SEC_LAST);
    assign half_hit = (sec_cnt == HALF_LAST);
    assign pct_wrap = (pct_cnt == PCT_LAST);

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            sec_cnt <= '0;
            pct_cnt <= '0;
            ticks_o <= '0;
            blink_o <= 1'b0;
        end else begin
            ticks_o.second      <= sec_wrap;
            ticks_o.half_second <= sec_wrap | half_hit; // midpoint and end of second
            ticks_o.percent     <= pct_wrap;

            if (sec_wrap) begin
                sec_cnt <= '0;
                pct_cnt <= '0; // percent restarts with each second
            end else begin
                sec_cnt <= sec_cnt + 1'b1;
                if (pct_wrap) begin
                    pct_cnt <= '0;
                end else begin
                    pct_cnt <= pct_cnt + 1'b1;
                end
            end

            if (ticks_o.half_second) begin
                blink_o <= ~blink_o;
            end
        end
    end

endmodule

`default_nettype wire

/* source/button_debouncer.sv */
// synchroniser and stable-count debouncer for one active-low button pin
`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
    parameter int unsigned DEBOUNCE_CYCLES = 65536
) (
    input  logic gClk,
    input  logic lock_o,
    input  logic btn_n_i,
    output logic pressed_o
);
    import board_pkg::*;

    localparam int unsigned CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [SYNC_STAGES-1:0] sync_q;
    logic [CNT_W-1:0]       stable_cnt;
    logic                   sample;

    assign sample = ~sync_q[SYNC_STAGES-1]; // active high

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            sync_q     <= '1; // released
            stable_cnt <= '0;
            pressed_o  <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], btn_n_i};
            if (sample != pressed_o) begin
                if (stable_cnt == CNT_LAST) begin
                    pressed_o  <= sample;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0; // any agreement restarts the count
            end
        end
    end

endmodule

`default_nettype wire

/* source/button_conditioner.sv */
// debounces the game buttons, merges the mcu buttons and gates the menu request
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
    parameter int unsigned DEBOUNCE_CYCLES = 65536
) (
    input  logic                     gClk,
    input  logic                     lock_o,
    input  board_pkg::game_buttons_t btn_n_i,
    input  logic                     menu_n_i,
    input  board_pkg::mcu_buttons_t  mcu_buttons_i,
    input  logic                     menu_init_i,
    input  logic                     cart_present_i,
    output board_pkg::game_buttons_t buttons_o,
    output logic                     menu_o
);
    import board_pkg::*;

    localparam int unsigned NUM_BTN = $bits(game_buttons_t);

    logic [NUM_BTN-1:0] raw_n;
    logic [NUM_BTN-1:0] debounced;
    logic [NUM_BTN-1:0] mcu_game;
    logic               menu_req;

    assign raw_n    = btn_n_i;
    assign mcu_game = mcu_buttons_i.game;

    for (genvar i = 0; i < NUM_BTN; i++) begin : g_btn
        button_debouncer #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) u_debouncer (
            .gClk     (gClk),
            .lock_o   (lock_o),
            .btn_n_i  (raw_n[i]),
            .pressed_o(debounced[i])
        );
    end

    assign buttons_o = game_buttons_t'(debounced | mcu_game);

    // menu pin is active low, mcu bit active high
    assign menu_req = ~menu_n_i | mcu_buttons_i.menu;
    assign menu_o   = menu_init_i & cart_present_i & menu_req; // no menu without a cart

endmodule

`default_nettype wire

/* source/cart_detect.sv */
// cart-detect history giving a memory reset pulse per stable edge and a cart-present flag
`timescale 1ns/1ps
`default_nettype none

module cart_detect (
    input  logic gClk,
    input  logic lock_o,
    input  logic cart_det_i,
    output logic mem_reset_o,
    output logic cart_present_o
);
    import board_pkg::*;

    localparam int unsigned WIN_LEN    = 16;
    localparam int unsigned PRESENT_HI = 6;
    localparam int unsigned PRESENT_LO = 3;

    localparam logic [WIN_LEN-1:0] INSERT_PAT = {1'b0, {(WIN_LEN - 1){1'b1}}};
    localparam logic [WIN_LEN-1:0] REMOVE_PAT = {1'b1, {(WIN_LEN - 1){1'b0}}};

    logic [CART_HIST_LEN-1:0] hist;
    logic [WIN_LEN-1:0]       window;
    logic                     edge_seen;

    assign window    = hist[CART_HIST_LEN-1 -: WIN_LEN]; // oldest samples
    assign edge_seen = (window == INSERT_PAT) || (window == REMOVE_PAT);

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            hist        <= '0; // no cart
            mem_reset_o <= 1'b0;
        end else begin
            hist        <= {hist[CART_HIST_LEN-2:0], cart_det_i};
            mem_reset_o <= edge_seen;
        end
    end

    assign cart_present_o = &hist[PRESENT_HI:PRESENT_LO];

endmodule

`default_nettype wire

/* source/status_led.sv */
// priority encoder from led requests to the registered active-low rgb pins
`timescale 1ns/1ps
`default_nettype none

module status_led (
    input  logic                gClk,
    input  logic                lock_o,
    input  board_pkg::led_req_t led_req_i,
    input  logic                blink_i,
    output board_pkg::led_rgb_t led_rgb_n_o
);

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            led_rgb_n_o <= '1; // all off
        end else begin
            if (led_req_i.white) begin
                led_rgb_n_o.r <= 1'b0;
                led_rgb_n_o.g <= 1'b0;
                led_rgb_n_o.b <= 1'b0;
            end else if (led_req_i.green) begin
                led_rgb_n_o.r <= 1'b1;
                led_rgb_n_o.g <= 1'b0;
                led_rgb_n_o.b <= 1'b1;
            end else if (led_req_i.yellow) begin
                led_rgb_n_o.r <= 1'b0;
                led_rgb_n_o.g <= blink_i; // flashes between red and yellow
                led_rgb_n_o.b <= 1'b1;
            end else if (led_req_i.red) begin
                // red and green pins together, per board wiring
                led_rgb_n_o.r <= 1'b0;
                led_rgb_n_o.g <= 1'b0;
                led_rgb_n_o.b <= 1'b1;
            end else begin
                led_rgb_n_o.r <= 1'b1;
                led_rgb_n_o.g <= 1'b1;
                led_rgb_n_o.b <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/hash_capture.sv */
// brings the game hash valid into gClk and latches the hash on its rising edge
`timescale 1ns/1ps
`default_nettype none

module hash_capture (
    input  logic                  gClk,
    input  logic                  lock_o,
    input  board_pkg::game_hash_t hash_i,
    input  logic                  hash_valid_i,
    output board_pkg::game_hash_t hash_o,
    output logic                  hash_valid_o
);
    import board_pkg::*;

    logic [SYNC_STAGES-1:0] valid_sync;
    logic                   valid_d;
    logic                   valid_rise;

    assign hash_valid_o = valid_sync[SYNC_STAGES-1];
    assign valid_rise   = hash_valid_o & ~valid_d;

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            valid_sync <= '0;
            valid_d    <= 1'b0;
        end else begin
            valid_sync <= {valid_sync[SYNC_STAGES-2:0], hash_valid_i};
            valid_d    <= hash_valid_o;
        end
    end

    // hash is stable in its own domain while valid is high
    always_ff @(posedge gClk) begin
        if (valid_rise) begin
            hash_o <= hash_i;
        end
    end

endmodule

`default_nettype wire

/* source/board_ctrl_top.sv */
// top level of the board-control glue, wires timebase, buttons, cart detect, led and hash
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top #(
    parameter int unsigned TICKS_PER_SECOND  = 8388608,
    parameter int unsigned TICKS_PER_PERCENT = 83887,
    parameter int unsigned DEBOUNCE_CYCLES   = 65536
) (
    input  logic                     gClk,
    input  logic                     lock_o,

    input  board_pkg::game_buttons_t btn_n_i,
    input  logic                     menu_n_i,
    input  board_pkg::mcu_buttons_t  mcu_buttons_i,
    input  logic                     menu_init_i,

    input  logic                     cart_det_i,

    input  board_pkg::led_req_t      led_req_i,

    input  board_pkg::game_hash_t    hash_i,
    input  logic                     hash_valid_i,

    output board_pkg::game_buttons_t buttons_o,
    output logic                     menu_o,

    output logic                     mem_reset_o,
    output logic                     cart_present_o,

    output board_pkg::tick_t         ticks_o,

    output board_pkg::led_rgb_t      led_rgb_n_o,

    output board_pkg::game_hash_t    hash_o,
    output logic                     hash_valid_o
);

    logic blink;

    board_timebase #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND),
        .TICKS_PER_PERCENT(TICKS_PER_PERCENT)
    ) u_timebase (
        .gClk   (gClk),
        .lock_o (lock_o),
        .ticks_o(ticks_o),
        .blink_o(blink)
    );

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_buttons (
        .gClk          (gClk),
        .lock_o        (lock_o),
        .btn_n_i       (btn_n_i),
        .menu_n_i      (menu_n_i),
        .mcu_buttons_i (mcu_buttons_i),
        .menu_init_i   (menu_init_i),
        .cart_present_i(cart_present_o),
        .buttons_o     (buttons_o),
        .menu_o        (menu_o)
    );

    cart_detect u_cart_detect (
        .gClk          (gClk),
        .lock_o        (lock_o),
        .cart_det_i    (cart_det_i),
        .mem_reset_o   (mem_reset_o),
        .cart_present_o(cart_present_o)
    );

    status_led u_status_led (
        .gClk       (gClk),
        .lock_o     (lock_o),
        .led_req_i  (led_req_i),
        .blink_i    (blink),
        .led_rgb_n_o(led_rgb_n_o)
    );

    hash_capture u_hash_capture (
        .gClk        (gClk),
        .lock_o      (lock_o),
        .hash_i      (hash_i),
        .hash_valid_i(hash_valid_i),
        .hash_o      (hash_o),
        .hash_valid_o(hash_valid_o)
    );

endmodule

`default_nettype wire

/* sim/board_ctrl_checks.svh */
// typed compare tasks and error counters, included inside the board-control testbench module
`ifndef BOARD_CTRL_CHECKS_SVH
`define BOARD_CTRL_CHECKS_SVH

int unsigned button_errors = 0;
int unsigned led_errors    = 0;
int unsigned hash_errors   = 0;
int unsigned bit_errors    = 0;
int unsigned count_errors  = 0;

task automatic compare_buttons(input string what, input game_buttons_t got,
                               input game_buttons_t expected);
    if (got !== expected) begin
        button_errors++;
        $display("** Error at %0t: %s buttons %h, expected %h", $time, what, got, expected);
    end
endtask

// a zero mask bit leaves that pin out of the compare
task automatic verify_led(input string what, input led_rgb_t got, input led_rgb_t expected,
                          input led_rgb_t mask);
    if ((got & mask) !== (expected & mask)) begin
        led_errors++;
        $display("** Error at %0t: %s led pins %b, expected %b under mask %b",
                 $time, what, got, expected, mask);
    end
endtask

task automatic match_hash(input string what, input game_hash_t got, input game_hash_t expected);
    if (got !== expected) begin
        hash_errors++;
        $display("** Error at %0t: %s hash %h, expected %h", $time, what, got, expected);
    end
endtask

task automatic test_bit(input string what, input logic got, input logic expected);
    if (got !== expected) begin
        bit_errors++;
        $display("** Error at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
endtask

task automatic expect_count(input string what, input int got, input int expected);
    if (got != expected) begin
        count_errors++;
        $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
endtask

function automatic int unsigned total_errors();
    return button_errors + led_errors + hash_errors + bit_errors + count_errors;
endfunction

`endif

/* sim/board_ctrl_tb.sv */
// testbench for board_ctrl_top that runs the steps of sim/board_input.txt and checks the outputs
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_tb;
    import board_pkg::*;

    localparam int unsigned TICKS_PER_SECOND  = 40;
    localparam int unsigned TICKS_PER_PERCENT = 3;
    localparam int unsigned DEBOUNCE_CYCLES   = 4;
    localparam int unsigned SHORT_GLITCH_MAX  = DEBOUNCE_CYCLES - 1; // never reaches the output
    localparam int unsigned LONG_GLITCH_MAX   = 14;
    localparam STIM_FILE = "sim/board_input.txt";

    localparam logic [3:0] KIND_RESET        = 4'd0;
    localparam logic [3:0] KIND_TIMEBASE     = 4'd1;
    localparam logic [3:0] KIND_SHORT_GLITCH = 4'd3;
    localparam logic [3:0] KIND_LONG_GLITCH  = 4'd4;

    typedef struct packed {
        logic [3:0]    kind;
        game_buttons_t btn_n;
        logic          menu_n;
        mcu_buttons_t  mcu;
        logic          menu_init;
        logic          cart_det;
        led_req_t      led_req;
        game_hash_t    hash;
        logic          hash_valid;
        logic [15:0]   hold;
        game_buttons_t exp_buttons;
        logic          exp_menu;
        logic          exp_cart;
        logic [7:0]    exp_resets;
        led_rgb_t      exp_led;
        led_rgb_t      led_mask;
        game_hash_t    exp_hash;
        logic          exp_hash_valid;
    } step_t;

    logic          gClk;
    logic          lock_o;
    game_buttons_t btn_n;
    logic          menu_n;
    mcu_buttons_t  mcu_buttons;
    logic          menu_init;
    logic          cart_det;
    led_req_t      led_req;
    game_hash_t    hash_in;
    logic          hash_valid_in;
    game_buttons_t buttons;
    logic          menu;
    logic          mem_reset;
    logic          cart_present;
    tick_t         ticks;
    led_rgb_t      led_rgb_n;
    game_hash_t    hash_out;
    logic          hash_valid_out;

    step_t       steps[$];
    step_t       applied;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 200;
    int          last_sec;
    int          last_pct;
    int unsigned halves;
    int unsigned percents;
    int unsigned seconds_seen;

    `include "board_ctrl_checks.svh"

    board_ctrl_top #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND),
        .TICKS_PER_PERCENT(TICKS_PER_PERCENT),
        .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES)
    ) board_ctrl_top_inst (
        .gClk          (gClk),
        .lock_o        (lock_o),
        .btn_n_i       (btn_n),
        .menu_n_i      (menu_n),
        .mcu_buttons_i (mcu_buttons),
        .menu_init_i   (menu_init),
        .cart_det_i    (cart_det),
        .led_req_i     (led_req),
        .hash_i        (hash_in),
        .hash_valid_i  (hash_valid_in),
        .buttons_o     (buttons),
        .menu_o        (menu),
        .mem_reset_o   (mem_reset),
        .cart_present_o(cart_present),
        .ticks_o       (ticks),
        .led_rgb_n_o   (led_rgb_n),
        .hash_o        (hash_out),
        .hash_valid_o  (hash_valid_out)
    );

    initial begin
        gClk = 1'b0;
        forever #50 gClk = ~gClk;
    end

    always @(posedge gClk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic load_steps(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [18];
        step_t       s;
        ok = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %h %h %d %h %h %h %h",
                                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                                col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                                col[15], col[16], col[17]);
                    if (n != 18) begin
                        $display("stimulus line cannot be read: %s", line);
                        ok = 1'b0;
                    end else begin
                        s.kind           = col[0][3:0];
                        s.btn_n          = col[1][7:0];
                        s.menu_n         = col[2][0];
                        s.mcu            = col[3][8:0];
                        s.menu_init      = col[4][0];
                        s.cart_det       = col[5][0];
                        s.led_req        = col[6][3:0];
                        s.hash           = col[7];
                        s.hash_valid     = col[8][0];
                        s.hold           = col[9][15:0];
                        s.exp_buttons    = col[10][7:0];
                        s.exp_menu       = col[11][0];
                        s.exp_cart       = col[12][0];
                        s.exp_resets     = col[13][7:0];
                        s.exp_led        = col[14][2:0];
                        s.led_mask       = col[15][2:0];
                        s.exp_hash       = col[16];
                        s.exp_hash_valid = col[17][0];
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
            if (steps.size() == 0) begin
                $display("the stimulus file holds no steps");
                ok = 1'b0;
            end
        end
    endtask

    task automatic apply_inputs(input step_t s);
        btn_n         <= s.btn_n;
        menu_n        <= s.menu_n;
        mcu_buttons   <= s.mcu;
        menu_init     <= s.menu_init;
        cart_det      <= s.cart_det;
        led_req       <= s.led_req;
        hash_in       <= s.hash;
        hash_valid_in <= s.hash_valid;
    endtask

    // spacing rules of the second, half-second and percent pulses
    task automatic watch_ticks(input string what);
        int gap;
        if (ticks.second) begin
            test_bit({what, " half_second with second"}, ticks.half_second, 1'b1);
            if (last_sec >= 0) begin
                gap = int'(cycle_cnt) - last_sec;
                expect_count({what, " cycles between seconds"}, gap, TICKS_PER_SECOND);
                expect_count({what, " half_seconds between seconds"}, halves, 1);
                expect_count({what, " percents between seconds"}, percents,
                             TICKS_PER_SECOND / TICKS_PER_PERCENT);
            end
            last_sec = cycle_cnt;
            halves   = 0;
            percents = 0;
            seconds_seen++;
        end else if (ticks.half_second) begin
            halves++;
        end
        if (ticks.percent) begin
            if (last_pct >= 0) begin
                gap = int'(cycle_cnt) - last_pct;
                test_bit({what, " percent spacing not below limit"},
                         gap >= int'(TICKS_PER_PERCENT), 1'b1);
            end
            last_pct = cycle_cnt;
            percents++;
        end
    endtask

    task automatic run_step(input step_t s, input step_t prev, input int unsigned idx);
        string       what;
        int unsigned glitch_len;
        int unsigned pulses;
        int unsigned c;
        what   = $sformatf("step %0d", idx);
        pulses = 0;
        last_sec     = -1;
        last_pct     = -1;
        halves       = 0;
        percents     = 0;
        seconds_seen = 0;
        @(posedge gClk);
        apply_inputs(s);
        if (s.kind == KIND_SHORT_GLITCH || s.kind == KIND_LONG_GLITCH) begin
            glitch_len = (s.kind == KIND_SHORT_GLITCH) ? $urandom_range(SHORT_GLITCH_MAX, 1)
                                                       : $urandom_range(LONG_GLITCH_MAX, 1);
            for (c = 0; c < glitch_len; c++) begin
                @(negedge gClk);
                pulses += mem_reset;
                @(posedge gClk);
            end
            apply_inputs(prev); // restore the settled inputs after the glitch
        end
        for (c = 1; c <= s.hold; c++) begin
            @(negedge gClk);
            pulses += mem_reset;
            if (s.kind == KIND_TIMEBASE) begin
                watch_ticks(what);
            end
            if (c < s.hold) begin
                @(posedge gClk);
            end
        end
        if (s.kind == KIND_RESET) begin
            test_bit({what, " any tick"}, |ticks, 1'b0);
        end
        if (s.kind == KIND_TIMEBASE) begin
            test_bit({what, " enough seconds seen"},
                     seconds_seen + 1 >= s.hold / TICKS_PER_SECOND, 1'b1);
        end
        compare_buttons(what, buttons, s.exp_buttons);
        test_bit({what, " menu"}, menu, s.exp_menu);
        test_bit({what, " cart_present"}, cart_present, s.exp_cart);
        expect_count({what, " mem_reset pulses"}, pulses, s.exp_resets);
        verify_led(what, led_rgb_n, s.exp_led, s.led_mask);
        test_bit({what, " hash_valid"}, hash_valid_out, s.exp_hash_valid);
        if (s.exp_hash_valid) begin
            match_hash(what, hash_out, s.exp_hash);
        end
    endtask

    initial begin
        bit          loaded;
        int unsigned hold_sum;
        void'($urandom(2137));
        lock_o        = 1'b0;
        btn_n         = '1; // released
        menu_n        = 1'b1;
        mcu_buttons   = '0;
        menu_init     = 1'b0;
        cart_det      = 1'b0;
        led_req       = '0;
        hash_in       = '0;
        hash_valid_in = 1'b0;
        applied       = '0;
        applied.btn_n  = '1;
        applied.menu_n = 1'b1;
        load_steps(loaded);
        if (!loaded) begin
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            hold_sum = 0;
            foreach (steps[i]) begin
                hold_sum += steps[i].hold;
            end
            cycle_limit = 2 * hold_sum + 200;
            repeat (2) @(posedge gClk);
            lock_o <= 1'b1;
            foreach (steps[i]) begin
                run_step(steps[i], applied, i);
                if (steps[i].kind != KIND_SHORT_GLITCH && steps[i].kind != KIND_LONG_GLITCH) begin
                    applied = steps[i];
                end
            end
            $display("errors: buttons %0d, led %0d, hash %0d, bits %0d, counts %0d",
                     button_errors, led_errors, hash_errors, bit_errors, count_errors);
            if (total_errors() == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+sim
source/board_pkg.sv
source/board_timebase.sv
source/button_debouncer.sv
source/button_conditioner.sv
source/cart_detect.sv
source/status_led.sv
source/hash_capture.sv
source/board_ctrl_top.sv
sim/board_ctrl_tb.sv

/* sim/board_input.txt */
# kind btn_n menu_n mcu menu_init cart_det led_req hash hash_valid hold(dec) | expected: buttons menu cart_present mem_reset_pulses(dec) led_pins led_mask hash hash_valid
# kind 0 reset state, 1 timebase watch, 2 drive and hold, 3 button glitch 1..3 cycles, 4 cart glitch 1..14 cycles
0 ff 1 000 0 0 0 00000000 0 1    00 0 0 0 7 7 00000000 0
1 ff 1 000 0 0 0 00000000 0 200  00 0 0 0 7 7 00000000 0
2 fe 1 000 0 0 0 00000000 0 10   01 0 0 0 7 7 00000000 0
2 ff 1 000 0 0 0 00000000 0 10   00 0 0 0 7 7 00000000 0
3 7f 1 000 0 0 0 00000000 0 10   00 0 0 0 7 7 00000000 0
2 7f 1 000 0 0 0 00000000 0 10   80 0 0 0 7 7 00000000 0
3 ff 1 000 0 0 0 00000000 0 10   80 0 0 0 7 7 00000000 0
2 ff 1 000 0 0 0 00000000 0 10   00 0 0 0 7 7 00000000 0
2 5a 1 000 0 0 0 00000000 0 10   a5 0 0 0 7 7 00000000 0
2 ff 1 000 0 0 0 00000000 0 10   00 0 0 0 7 7 00000000 0
2 ff 1 010 0 0 0 00000000 0 2    10 0 0 0 7 7 00000000 0
2 ff 1 0a5 0 0 0 00000000 0 2    a5 0 0 0 7 7 00000000 0
2 ff 1 000 0 0 0 00000000 0 2    00 0 0 0 7 7 00000000 0
2 ff 0 000 1 0 0 00000000 0 3    00 0 0 0 7 7 00000000 0
2 ff 1 100 1 0 0 00000000 0 3    00 0 0 0 7 7 00000000 0
2 ff 1 000 1 1 0 00000000 0 30   00 0 1 1 7 7 00000000 0
2 ff 0 000 1 1 0 00000000 0 3    00 1 1 0 7 7 00000000 0
2 ff 0 000 0 1 0 00000000 0 3    00 0 1 0 7 7 00000000 0
2 ff 1 100 1 1 0 00000000 0 3    00 1 1 0 7 7 00000000 0
2 ff 1 000 1 1 0 00000000 0 3    00 0 1 0 7 7 00000000 0
2 ff 1 000 1 0 0 00000000 0 30   00 0 0 1 7 7 00000000 0
2 ff 1 000 1 1 0 00000000 0 6    00 0 0 0 7 7 00000000 0
4 ff 1 000 1 0 0 00000000 0 30   00 0 1 1 7 7 00000000 0
2 ff 1 000 1 1 0 00000000 0 3    00 0 1 0 7 7 00000000 0
2 ff 1 000 1 1 1 00000000 0 3    00 0 1 0 1 7 00000000 0
2 ff 1 000 1 1 2 00000000 0 3    00 0 1 0 1 5 00000000 0
2 ff 1 000 1 1 3 00000000 0 3    00 0 1 0 1 5 00000000 0
2 ff 1 000 1 1 4 00000000 0 3    00 0 1 0 5 7 00000000 0
2 ff 1 000 1 1 6 00000000 0 3    00 0 1 0 5 7 00000000 0
2 ff 1 000 1 1 8 00000000 0 3    00 0 1 0 0 7 00000000 0
2 ff 1 000 1 1 a 00000000 0 3    00 0 1 0 0 7 00000000 0
2 ff 1 000 1 1 f 00000000 0 3    00 0 1 0 0 7 00000000 0
2 ff 1 000 1 1 0 00000000 0 3    00 0 1 0 7 7 00000000 0
2 ff 1 000 1 1 0 12345678 1 5    00 0 1 0 7 7 12345678 1
2 ff 1 000 1 1 0 cafef00d 1 5    00 0 1 0 7 7 12345678 1
2 ff 1 000 1 1 0 cafef00d 0 5    00 0 1 0 7 7 00000000 0
2 ff 1 000 1 1 0 0badbeef 1 5    00 0 1 0 7 7 0badbeef 1
